/* source/gba_loader_pkg.sv */
package gba_loader_pkg;

	// ========================================
	// Download port and kinds
	// ========================================

	typedef struct packed {
		logic        download; // High for the whole transfer of one file
		logic [7:0]  index;    // File slot picked in the menu
		logic [26:0] addr;     // Byte address, steps by 2
		logic [15:0] data;     // Little-endian halfword
		logic        wr;       // One-cycle write strobe
	} ioctl_t;

	// Active download, registered from the index
	typedef enum logic [1:0] {
		dl_none,
		dl_bios,
		dl_cart,
		dl_cheat
	} dl_kind_e;

	localparam logic [7:0] BIOS_INDEX  = 8'd0;   // System BIOS image
	localparam logic [7:0] CHEAT_INDEX = 8'd255; // Cheat file, any other index is a cart

	// ========================================
	// Write buses toward the core
	// ========================================

	typedef struct packed {
		logic        req;  // Pulse, storage answers with one ack
		logic [25:0] addr; // Halfword address
		logic [15:0] data;
	} rom_wr_t;

	// Cart ROM sits behind flash/EEPROM and work RAM in storage
	localparam logic [26:0] ROM_START_BYTE = 27'd786432;

	typedef struct packed {
		logic        wr;   // One-cycle write
		logic [11:0] addr; // 32-bit word address
		logic [31:0] data;
	} bios_wr_t;

	// Field order matches the 128-bit code layout, flags on top
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// ========================================
	// Cartridge scan
	// ========================================

	typedef struct packed {
		logic        loaded;             // Set once any cart has been loaded
		logic [1:0]  cart_type;          // Index bits 7:6
		logic        flash_1m;           // Large flash tag seen somewhere in the ROM
		logic        sram_quirk;         // Title needs SRAM/flash access disabled
		logic        memory_remap_quirk; // Title also needs the mirrored ROM map
		logic [26:0] last_addr;          // Byte address of the final cart write
	} cart_info_t;

	typedef struct packed {
		logic [95:0] title; // First character in the top byte, zero padded
		logic        remap;
	} quirk_entry_t;

	localparam logic [71:0] FLASH_TAG   = "FLASH1M_V";
	localparam logic [22:0] TITLE_LINE  = 23'hA; // Header bytes 'hA0..'hAF
	localparam int          TITLE_BYTES = 12;
	localparam int          QUIRK_COUNT = 6;

	// Short excerpt of the title list
	localparam quirk_entry_t QUIRK_TABLE [QUIRK_COUNT] = '{
		'{title: {"ROCKY BOXING"},            remap: 1'b0}, // Boxing title
		'{title: {"DBZ TAIKETSU"},            remap: 1'b0}, // Fighting title
		'{title: {"IRIDIONII", 24'h000000},   remap: 1'b0}, // Shooter, both regions
		'{title: {"SUPER MARIO", 8'h00},      remap: 1'b1}, // 8-bit port, needs remap
		'{title: {"DONKEY KONG", 8'h00},      remap: 1'b1},
		'{title: {"ZELDA 1", 40'h0000000000}, remap: 1'b1}
	};

endpackage

/* source/download_decoder.sv */
`timescale 1ns/100ps

module download_decoder (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gba_loader_pkg::ioctl_t    ioctl,
	input  logic                      rom_ack,    // One pulse per ROM request
	output gba_loader_pkg::dl_kind_e  dl_kind,
	output logic                      dl_start,   // Raw rising edge of download
	output gba_loader_pkg::rom_wr_t   rom_wr,
	output logic                      ioctl_wait  // Holds the host off during a ROM write
);

	gba_loader_pkg::dl_kind_e kind_next;
	logic                     download_q;  // Download flag one cycle back
	logic                     cart_write;  // Host write that goes to ROM
	logic [26:0]              rom_byte;    // Storage byte address of this write

	// ========================================
	// Download kind
	// ========================================

	// Index 0 is BIOS, 255 is cheats, the rest are cartridges
	always_comb begin
		if (!ioctl.download)
			kind_next = gba_loader_pkg::dl_none;
		else if (ioctl.index == gba_loader_pkg::BIOS_INDEX)
			kind_next = gba_loader_pkg::dl_bios;
		else if (ioctl.index == gba_loader_pkg::CHEAT_INDEX)
			kind_next = gba_loader_pkg::dl_cheat;
		else
			kind_next = gba_loader_pkg::dl_cart;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_kind    <= gba_loader_pkg::dl_none;
			download_q <= 1'b0;
		end else begin
			dl_kind    <= kind_next; // One cycle behind the port
			download_q <= ioctl.download;
		end
	end

	// Unregistered, the cheat block registers it with the index
	assign dl_start = ioctl.download & ~download_q;

	// ========================================
	// ROM write path
	// ========================================

	assign cart_write = (dl_kind == gba_loader_pkg::dl_cart) & ioctl.wr;
	assign rom_byte   = ioctl.addr + gba_loader_pkg::ROM_START_BYTE; // Wraps inside 128 MB

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_wr.req <= 1'b0;
		end else begin
			rom_wr.req <= cart_write; // Single-cycle request
		end

		// Address and data stay valid until the next cart write
		if (cart_write) begin
			rom_wr.addr <= rom_byte[26:1]; // Halfword units
			rom_wr.data <= ioctl.data;
		end
	end

	// Wait rises with the request and drops the cycle after the ack,
	// the ack wins if both land together
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait <= 1'b0;
		end else if (dl_kind != gba_loader_pkg::dl_cart) begin
			ioctl_wait <= 1'b0; // Download over, never leave the host stuck
		end else begin
			if (cart_write)
				ioctl_wait <= 1'b1;
			if (rom_ack)
				ioctl_wait <= 1'b0;
		end
	end

endmodule

/* source/cart_header_scan.sv */
`timescale 1ns/100ps

module cart_header_scan (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gba_loader_pkg::ioctl_t    ioctl,
	input  gba_loader_pkg::dl_kind_e  dl_kind,
	output gba_loader_pkg::cart_info_t cart_info
);

	logic        cart_active;   // Cartridge download in progress
	logic        cart_active_q;
	logic        cart_begin;    // First cycle of a cart download
	logic        cart_end;      // First cycle after it
	logic        cart_wr;
	logic [63:0] history;       // Last eight bytes in file order
	logic        tag_at_lo;     // Tag completed by the low byte
	logic        tag_at_hi;     // Tag completed by the high byte
	logic [26:0] last_wr_addr;
	logic        title_line;    // Write lands in the header title line
	logic        title_wr;
	logic        title_check;   // Write just past the title
	logic [6:0]  title_pos;     // Bit position of this halfword in title
	logic [95:0] title;
	logic        quirk_hit;
	logic        quirk_remap;

	// ========================================
	// Download framing
	// ========================================

	assign cart_active = (dl_kind == gba_loader_pkg::dl_cart);
	assign cart_begin  = cart_active & ~cart_active_q;
	assign cart_end    = ~cart_active & cart_active_q;
	assign cart_wr     = cart_active & ioctl.wr;

	// ========================================
	// Flash tag search
	// ========================================

	// Low byte comes first in the file
	assign tag_at_lo = ({history, ioctl.data[7:0]} == gba_loader_pkg::FLASH_TAG);
	assign tag_at_hi = ({history[55:0], ioctl.data[7:0], ioctl.data[15:8]}
		== gba_loader_pkg::FLASH_TAG);

	// ========================================
	// Title and quirks
	// ========================================

	assign title_line  = (ioctl.addr[26:4] == gba_loader_pkg::TITLE_LINE);
	assign title_wr    = cart_wr & title_line
		& (ioctl.addr[3:0] < gba_loader_pkg::TITLE_BYTES);
	assign title_check = cart_wr & title_line
		& (ioctl.addr[3:0] == gba_loader_pkg::TITLE_BYTES);

	// Offset 0 goes to the top of the title, offset 10 to the bottom
	assign title_pos = 7'((gba_loader_pkg::TITLE_BYTES - 2 - ioctl.addr[3:0]) * 8);

	// Match the gathered title against every table entry
	always_comb begin
		quirk_hit   = 1'b0;
		quirk_remap = 1'b0;
		for (int i = 0; i < gba_loader_pkg::QUIRK_COUNT; i++) begin
			if (title == gba_loader_pkg::QUIRK_TABLE[i].title) begin
				quirk_hit   = 1'b1;
				quirk_remap = quirk_remap | gba_loader_pkg::QUIRK_TABLE[i].remap;
			end
		end
	end

	// Byte history, title bytes and last address
	always_ff @(posedge clk_sys) begin
		if (cart_begin)
			history <= '0; // No tag across two files
		else if (cart_wr)
			history <= {history[47:0], ioctl.data[7:0], ioctl.data[15:8]};

		if (cart_wr)
			last_wr_addr <= ioctl.addr;

		if (title_wr)
			title[title_pos +: 16] <= {ioctl.data[7:0], ioctl.data[15:8]};
	end

	// ========================================
	// Cartridge info
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_active_q <= 1'b0;
			cart_info     <= '0;
		end else begin
			cart_active_q <= cart_active;

			// New cart, forget everything from the previous one
			if (cart_begin) begin
				cart_info.loaded             <= 1'b1;
				cart_info.cart_type          <= ioctl.index[7:6];
				cart_info.flash_1m           <= 1'b0;
				cart_info.sram_quirk         <= 1'b0;
				cart_info.memory_remap_quirk <= 1'b0;
			end

			if (cart_wr && (tag_at_lo || tag_at_hi))
				cart_info.flash_1m <= 1'b1; // Sticky until next cart

			if (title_check && quirk_hit) begin
				cart_info.sram_quirk         <= 1'b1;
				cart_info.memory_remap_quirk <= quirk_remap;
			end

			if (cart_end)
				cart_info.last_addr <= last_wr_addr; // Bounds reads past ROM end
		end
	end

endmodule

/* source/bios_word_packer.sv */
`timescale 1ns/100ps

module bios_word_packer (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gba_loader_pkg::ioctl_t    ioctl,
	input  gba_loader_pkg::dl_kind_e  dl_kind,
	output gba_loader_pkg::bios_wr_t  bios_wr
);

	logic        bios_active; // BIOS download in progress
	logic        bios_write;
	logic [15:0] low_half;    // First halfword of the pending word

	assign bios_active = (dl_kind == gba_loader_pkg::dl_bios);
	assign bios_write  = bios_active & ioctl.wr;

	// ========================================
	// Halfword pairing
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bios_wr.wr <= 1'b0;
		end else begin
			bios_wr.wr <= bios_write & ioctl.addr[1]; // Upper half completes the word
		end

		if (bios_write) begin
			if (!ioctl.addr[1]) begin
				low_half <= ioctl.data; // Held until its partner arrives
			end else begin
				bios_wr.data <= {ioctl.data, low_half};
				bios_wr.addr <= ioctl.addr[13:2]; // 16 KB BIOS in words
			end
		end
	end

endmodule

/* source/cheat_code_assembler.sv */
`timescale 1ns/100ps

module cheat_code_assembler (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  gba_loader_pkg::ioctl_t      ioctl,
	input  gba_loader_pkg::dl_kind_e    dl_kind,
	input  logic                        dl_start,    // Download flag just went high
	output gba_loader_pkg::cheat_code_t cheat_code,
	output logic                        cheat_valid, // Code complete
	output logic                        cheat_clear  // Drop all loaded codes
);

	logic cheat_write;

	assign cheat_write = (dl_kind == gba_loader_pkg::dl_cheat) & ioctl.wr;

	// ========================================
	// Control pulses
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// New cheat file replaces the whole list
			cheat_clear <= dl_start & (ioctl.index == gba_loader_pkg::CHEAT_INDEX);
			cheat_valid <= cheat_write & (ioctl.addr[3:0] == 4'd14); // Last halfword
		end
	end

	// ========================================
	// Code fields
	// ========================================

	// 16 bytes per code, each field stored low half first
	always_ff @(posedge clk_sys) begin
		if (cheat_write) begin
			case (ioctl.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= ioctl.data;
				4'd2:  cheat_code.flags[31:16]   <= ioctl.data;
				4'd4:  cheat_code.address[15:0]  <= ioctl.data;
				4'd6:  cheat_code.address[31:16] <= ioctl.data;
				4'd8:  cheat_code.compare[15:0]  <= ioctl.data;
				4'd10: cheat_code.compare[31:16] <= ioctl.data;
				4'd12: cheat_code.replace[15:0]  <= ioctl.data;
				4'd14: cheat_code.replace[31:16] <= ioctl.data; // Valid follows
				default: ; // Odd offsets never come from the host
			endcase
		end
	end

endmodule

/* source/gba_loader_top.sv */
`timescale 1ns/100ps

module gba_loader_top (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  gba_loader_pkg::ioctl_t      ioctl,
	input  logic                        rom_ack,
	output logic                        ioctl_wait,
	output gba_loader_pkg::rom_wr_t     rom_wr,
	output gba_loader_pkg::bios_wr_t    bios_wr,
	output gba_loader_pkg::cart_info_t  cart_info,
	output gba_loader_pkg::cheat_code_t cheat_code,
	output logic                        cheat_valid,
	output logic                        cheat_clear
);

	gba_loader_pkg::dl_kind_e dl_kind;  // Shared by all three sinks
	logic                     dl_start;

	// ========================================
	// Port decode and ROM handshake
	// ========================================

	download_decoder download_decoder_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ioctl      (ioctl),
		.rom_ack    (rom_ack),
		.dl_kind    (dl_kind),
		.dl_start   (dl_start),
		.rom_wr     (rom_wr),
		.ioctl_wait (ioctl_wait)
	);

	// ========================================
	// Per-kind sinks
	// ========================================

	cart_header_scan cart_header_scan_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ioctl     (ioctl),
		.dl_kind   (dl_kind),
		.cart_info (cart_info)
	);

	bios_word_packer bios_word_packer_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ioctl   (ioctl),
		.dl_kind (dl_kind),
		.bios_wr (bios_wr)
	);

	cheat_code_assembler cheat_code_assembler_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.dl_kind     (dl_kind),
		.dl_start    (dl_start),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

endmodule

/* dv/tb_gba_loader.sv */
`timescale 1ns/100ps

module tb_gba_loader;

	logic                        clk_sys;
	logic                        reset;
	gba_loader_pkg::ioctl_t      ioctl;
	logic                        rom_ack;
	logic                        ioctl_wait;
	gba_loader_pkg::rom_wr_t     rom_wr;
	gba_loader_pkg::bios_wr_t    bios_wr;
	gba_loader_pkg::cart_info_t  cart_info;
	gba_loader_pkg::cheat_code_t cheat_code;
	logic                        cheat_valid;
	logic                        cheat_clear;

	gba_loader_pkg::rom_wr_t  rom_seen [$];     // Requests as the DUT issued them
	gba_loader_pkg::rom_wr_t  rom_expected [$]; // One per host cart write
	gba_loader_pkg::bios_wr_t bios_seen [$];
	string  case_lines [$];
	string  test_name = "";
	integer seed = 32'h870b_77a3;
	int     valid_pulses = 0;
	int     clear_pulses = 0;
	int     errors = 0;
	int     checks = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	int     test_first_error = 0;
	int     budget_cycles = 100;
	logic   budget_ready = 1'b0;
	logic   cart_download = 1'b0; // Current index is neither BIOS nor cheat

	gba_loader_top gba_loader_top_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.rom_ack     (rom_ack),
		.ioctl_wait  (ioctl_wait),
		.rom_wr      (rom_wr),
		.bios_wr     (bios_wr),
		.cart_info   (cart_info),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	// ========================================
	// Storage model and monitors
	// ========================================

	// One ack per request within 1 to 6 cycles
	initial begin
		int ack_delay;
		rom_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rom_wr.req) begin
				ack_delay = 1 + ({$random(seed)} % 6);
				repeat (ack_delay) @(posedge clk_sys);
				#1 rom_ack = 1'b1;
				@(posedge clk_sys);
				#1 rom_ack = 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (rom_wr.req)
			rom_seen.push_back(rom_wr);
		if (bios_wr.wr)
			bios_seen.push_back(bios_wr);
		if (cheat_valid)
			valid_pulses++; // Pulses are one cycle wide
		if (cheat_clear)
			clear_pulses++;
	end

	// Budget scales with the number of case lines
	initial begin
		wait (budget_ready);
		repeat (budget_cycles) @(posedge clk_sys);
		$display("Timeout after %0d cycles, the run did not complete", budget_cycles);
		$display("=== FAIL ===");
		$finish;
	end

	// ========================================
	// Compare tasks
	// ========================================

	task automatic check_rom_wr(input string name, input gba_loader_pkg::rom_wr_t got,
			input gba_loader_pkg::rom_wr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bios_wr(input string name, input gba_loader_pkg::bios_wr_t got,
			input gba_loader_pkg::bios_wr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_cart_info(input string name, input gba_loader_pkg::cart_info_t got,
			input gba_loader_pkg::cart_info_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_cheat_code(input string name, input gba_loader_pkg::cheat_code_t got,
			input gba_loader_pkg::cheat_code_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// ========================================
	// Host side of the download port
	// ========================================

	task automatic start_download(input logic [7:0] index);
		@(posedge clk_sys);
		#1;
		ioctl.index    = index;
		ioctl.download = 1'b1;
		cart_download  = (index != 8'h00) && (index != 8'hff); // Index rule for carts
		repeat (2) @(posedge clk_sys); // Download leads the first write
	endtask

	// Cart writes wait for the ack and watch ioctl_wait on every cycle
	task automatic write_halfword(input logic [26:0] addr, input logic [15:0] data);
		gba_loader_pkg::rom_wr_t exp_wr;
		int                      waited;
		@(posedge clk_sys);
		#1;
		ioctl.addr = addr;
		ioctl.data = data;
		ioctl.wr   = 1'b1;
		@(posedge clk_sys);
		#1 ioctl.wr = 1'b0;
		if (cart_download) begin
			exp_wr.req  = 1'b1;
			exp_wr.addr = 26'((addr + gba_loader_pkg::ROM_START_BYTE) / 2); // Halfword units
			exp_wr.data = data;
			rom_expected.push_back(exp_wr);
			waited = 0;
			do begin
				@(negedge clk_sys);
				waited++;
				check_bit("ioctl_wait", ioctl_wait, 1'b1); // Held until ack is taken
			end while (!rom_ack && waited < 20);
			if (!rom_ack) begin
				errors++;
				$display("No rom_ack within 20 cycles of the write to 0x%h", addr);
			end else begin
				@(negedge clk_sys);
				check_bit("ioctl_wait", ioctl_wait, 1'b0); // Released one cycle after ack
			end
		end
	endtask

	// Halfword k takes bytes 2k and 2k+1 with the low byte first in the file
	task automatic write_block(input logic [26:0] addr, input int count,
			input logic [127:0] bytes);
		logic [15:0] half;
		for (int k = 0; k < count; k++) begin
			half = {bytes[(2 * count - 2 - 2 * k) * 8 +: 8],
				bytes[(2 * count - 1 - 2 * k) * 8 +: 8]};
			write_halfword(addr + 27'(2 * k), half);
		end
	endtask

	task automatic end_download;
		repeat (2) @(posedge clk_sys);
		#1 ioctl.download = 1'b0;
		repeat (3) @(posedge clk_sys); // End address lands 2 cycles later
		@(negedge clk_sys);
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_count("rom_wr count", rom_seen.size(), rom_expected.size());
		foreach (rom_expected[i])
			if (i < rom_seen.size())
				check_rom_wr($sformatf("rom_wr[%0d]", i), rom_seen[i], rom_expected[i]);
		rom_seen.delete();
		rom_expected.delete();
		cart_download = 1'b0;
	endtask

	// ========================================
	// Case file handling
	// ========================================

	task automatic close_test;
		if (test_name != "") begin
			if (bios_seen.size() != 0) begin
				errors++;
				$display("%0d BIOS writes were issued that no case expected", bios_seen.size());
				bios_seen.delete();
			end
			tests_run++;
			if (errors == test_first_error) begin
				$display("test %s: ok", test_name);
			end else begin
				tests_failed++;
				$display("test %s: %0d errors", test_name, errors - test_first_error);
			end
		end
		test_first_error = errors;
	endtask

	task automatic run_line(input string line);
		byte                         op;
		logic [127:0]                arg1, arg2, arg3, arg4, arg5, arg6;
		int                          count;
		gba_loader_pkg::cart_info_t  exp_info;
		gba_loader_pkg::cheat_code_t exp_code;
		gba_loader_pkg::bios_wr_t    exp_bios;
		op = line.getc(0);
		case (op)
			"T": begin
				close_test();
				void'($sscanf(line, "T %s", test_name));
			end
			"R": begin
				@(negedge clk_sys);
				check_bit("ioctl_wait", ioctl_wait, 1'b0);
				check_bit("rom_wr.req", rom_wr.req, 1'b0);
				check_bit("bios_wr.wr", bios_wr.wr, 1'b0);
				check_bit("cheat_valid", cheat_valid, 1'b0);
				check_bit("cheat_clear", cheat_clear, 1'b0);
				check_cart_info("cart_info", cart_info, '0);
			end
			"S": begin
				void'($sscanf(line, "S %h", arg1));
				start_download(arg1[7:0]);
			end
			"W": begin
				void'($sscanf(line, "W %h %d %h", arg1, count, arg2));
				write_block(arg1[26:0], count, arg2);
			end
			"E": end_download();
			"I": begin
				void'($sscanf(line, "I %h %h %h %h %h %h", arg1, arg2, arg3, arg4, arg5, arg6));
				exp_info                    = '0;
				exp_info.loaded             = arg1[0];
				exp_info.cart_type          = arg2[1:0];
				exp_info.flash_1m           = arg3[0];
				exp_info.sram_quirk         = arg4[0];
				exp_info.memory_remap_quirk = arg5[0];
				exp_info.last_addr          = arg6[26:0];
				@(negedge clk_sys);
				check_cart_info("cart_info", cart_info, exp_info);
			end
			"B": begin
				void'($sscanf(line, "B %h %h", arg1, arg2));
				exp_bios.wr   = 1'b1;
				exp_bios.addr = arg1[11:0];
				exp_bios.data = arg2[31:0];
				if (bios_seen.size() == 0) begin
					errors++;
					$display("Expected a BIOS write to word 0x%h but none was issued",
						exp_bios.addr);
				end else begin
					check_bios_wr("bios_wr", bios_seen.pop_front(), exp_bios);
				end
			end
			"Q": begin
				void'($sscanf(line, "Q %h %h %h %h", arg1, arg2, arg3, arg4));
				exp_code = '{flags: arg1[31:0], address: arg2[31:0],
					compare: arg3[31:0], replace: arg4[31:0]};
				@(negedge clk_sys);
				check_cheat_code("cheat_code", cheat_code, exp_code);
			end
			"P": begin
				void'($sscanf(line, "P %d %d", arg1, arg2));
				check_count("cheat_valid pulses", valid_pulses, int'(arg1));
				check_count("cheat_clear pulses", clear_pulses, int'(arg2));
				valid_pulses = 0;
				clear_pulses = 0;
			end
			default: begin
				errors++;
				$display("Unknown case line: %s", line);
			end
		endcase
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		int    fd;
		int    rc;
		string line;
		ioctl = '0;
		reset = 1'b1;
		fd = $fopen("dv/gba_loader_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open dv/gba_loader_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				if (rc > 0 && line.len() > 1 && line.getc(0) != "#")
					case_lines.push_back(line);
			end
			$fclose(fd);
		end
		budget_cycles = case_lines.size() * 20 + 100;
		budget_ready  = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1 reset = 1'b0;
		foreach (case_lines[i])
			run_line(case_lines[i]);
		close_test();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* vlog.f */
source/gba_loader_pkg.sv
source/download_decoder.sv
source/cart_header_scan.sv
source/bios_word_packer.sv
source/cheat_code_assembler.sv
source/gba_loader_top.sv
dv/tb_gba_loader.sv

/* dv/gba_loader_cases.txt */
# op and hex fields: T name | R | S index | W addr halfwords bytes (first byte leftmost) | E
# I loaded type flash sram remap last_addr | B addr data | Q flags addr cmp repl | P valid clear
T reset_state
R
T bios_packing
S 00
W 10 4 4433221188776655
E
B 004 11223344
B 005 55667788
T cart_sram_quirk_even_tag
S 41
W a0 7 524f434b5920424f58494e470000
W 100 5 464c415348314d5f5600
E
I 1 1 1 1 0 108
T cart_remap_quirk_odd_tag
S c2
W 200 5 00464c415348314d5f56
W a0 7 5a454c4441203100000000000000
E
I 1 3 1 1 1 ac
T cart_plain_clears_flags
S 81
W a0 7 484f4d454252455720444d4f0000
E
I 1 2 0 0 0 ac
T cheat_codes
S ff
W 0 8 785634122c1a0003ff00000063000000
Q 12345678 03001a2c 000000ff 00000063
W 10 8 080000000001000234120000cdab0000
Q 00000008 02000100 00001234 0000abcd
E
P 2 1
